//--- rtl/hdc_pkg.sv
package hdc_pkg;

    // ########################################
    // Widths and sizes.
    // ########################################
    localparam int HV_WIDTH      = 32;                 // Hypervector width.
    localparam int IM_DEPTH      = 1024;               // Number of item hypervectors.
    localparam int IM_ADDR_WIDTH = $clog2(IM_DEPTH);
    localparam int WB_ADDR_WIDTH = 12;                 // Host byte address.
    localparam int WB_WORD_LSB   = 2;                  // Byte offset within a 32-bit word.
    localparam int MAX_NGRAM     = 32;
    localparam int POS_WIDTH     = $clog2(MAX_NGRAM);

    typedef logic [HV_WIDTH-1:0]      hv_t;
    typedef logic [IM_ADDR_WIDTH-1:0] im_addr_t;    // Item index, also the symbol code.
    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
    typedef logic [POS_WIDTH-1:0]     pos_t;

    // ########################################
    // Host register map.
    // ########################################
    // Addresses below CTRL_ADDR reach the item memory, one word per entry.
    localparam wb_addr_t CTRL_ADDR    = 12'h400;
    localparam int       CTRL_LEN_MSB = POS_WIDTH - 1;  // Bits 4:0 hold ngram_len minus one.
    localparam int       CTRL_RUN_BIT = 8;

    // Item-memory requesters, in round-robin order.
    localparam int NUM_REQ = 3;
    typedef logic [1:0] req_idx_t;
    localparam req_idx_t REQ_HOST  = 2'd0;
    localparam req_idx_t REQ_LANE0 = 2'd1;
    localparam req_idx_t REQ_LANE1 = 2'd2;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_FETCH,
        LANE_EMIT
    } lane_state_t;

endpackage

//--- rtl/item_memory.sv
`timescale 1ns/1ps

module item_memory (
    input  logic              clk,
    input  logic              mem_en,
    input  logic              mem_we,
    input  hdc_pkg::im_addr_t mem_addr,
    input  hdc_pkg::hv_t      mem_wdata,
    output hdc_pkg::hv_t      mem_rdata
);
    import hdc_pkg::*;

    // One random hypervector per symbol code.
    (* ram_style = "block" *)
    hv_t ram [IM_DEPTH];

    // Single port with a registered read.
    // A write returns the old contents of the word on the same cycle,
    // so the port behaves as read-first.
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                ram[mem_addr] <= mem_wdata;
            end
            mem_rdata <= ram[mem_addr];    // Valid on the cycle after mem_en.
        end
    end

    // The read register holds its value between accesses, which lets the
    // arbiter hand the data back one cycle later without another register.

endmodule

//--- rtl/im_arbiter.sv
`timescale 1ns/1ps

module im_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    // Host requester, read and write.
    input  logic              h_cyc,
    input  logic              h_stb,
    input  logic              h_we,
    input  hdc_pkg::im_addr_t h_adr,
    input  hdc_pkg::hv_t      h_dat_w,
    output hdc_pkg::hv_t      h_dat_r,
    output logic              h_ack,
    // Lane 0 requester, read only.
    input  logic              l0_cyc,
    input  logic              l0_stb,
    input  hdc_pkg::im_addr_t l0_adr,
    output hdc_pkg::hv_t      l0_dat,
    output logic              l0_ack,
    // Lane 1 requester, read only.
    input  logic              l1_cyc,
    input  logic              l1_stb,
    input  hdc_pkg::im_addr_t l1_adr,
    output hdc_pkg::hv_t      l1_dat,
    output logic              l1_ack,
    // Item memory port.
    output logic              mem_en,
    output logic              mem_we,
    output hdc_pkg::im_addr_t mem_addr,
    output hdc_pkg::hv_t      mem_wdata,
    input  hdc_pkg::hv_t      mem_rdata
);
    import hdc_pkg::*;

    logic [NUM_REQ-1:0] req;
    req_idx_t           last_grant;   // Round-robin pointer and owner of the access in flight.
    req_idx_t           pick;
    logic               pick_valid;
    logic               ack_q;        // Second phase, read data is on mem_rdata.
    logic               launch;

    assign req = {l1_cyc & l1_stb, l0_cyc & l0_stb, h_cyc & h_stb};

    // Search starts at the requester after the last one granted.
    // The loop runs backwards so that the nearest candidate is assigned last.
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick       = last_grant;
        for (int k = NUM_REQ; k >= 1; k--) begin
            cand = (int'(last_grant) + k) % NUM_REQ;
            if (req[cand]) begin
                pick_valid = 1'b1;
                pick       = req_idx_t'(cand);
            end
        end
    end

    // New grants only when both phases are done.
    assign launch = pick_valid & ~mem_en & ~ack_q;

    // ########################################
    // Access sequencer.
    // ########################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_en     <= 1'b0;
            ack_q      <= 1'b0;
            last_grant <= REQ_LANE1;    // Host goes first after reset.
        end else begin
            mem_en <= launch;           // Phase one, the RAM read.
            ack_q  <= mem_en;           // Phase two, ack to the owner.
            if (launch) begin
                last_grant <= pick;
            end
        end
    end

    // Request payload is captured with the grant.
    always_ff @(posedge clk) begin
        if (launch) begin
            mem_wdata <= h_dat_w;
            unique case (pick)
                REQ_HOST: begin
                    mem_addr <= h_adr;
                    mem_we   <= h_we;
                end
                REQ_LANE0: begin
                    mem_addr <= l0_adr;
                    mem_we   <= 1'b0;
                end
                default: begin
                    mem_addr <= l1_adr;
                    mem_we   <= 1'b0;
                end
            endcase
        end
    end

    assign h_ack  = ack_q && (last_grant == REQ_HOST);
    assign l0_ack = ack_q && (last_grant == REQ_LANE0);
    assign l1_ack = ack_q && (last_grant == REQ_LANE1);

    // Read data is shared; only the owner sees an ack.
    assign h_dat_r = mem_rdata;
    assign l0_dat  = mem_rdata;
    assign l1_dat  = mem_rdata;

endmodule

//--- rtl/host_regs.sv
`timescale 1ns/1ps

module host_regs (
    input  logic              clk,
    input  logic              rst_n,
    // Wishbone classic slave toward the host.
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  hdc_pkg::wb_addr_t wb_adr,
    input  hdc_pkg::hv_t      wb_dat_w,
    output hdc_pkg::hv_t      wb_dat_r,
    output logic              wb_ack,
    // Wishbone classic master toward the arbiter.
    output logic              m_cyc,
    output logic              m_stb,
    output logic              m_we,
    output hdc_pkg::im_addr_t m_adr,
    output hdc_pkg::hv_t      m_dat_w,
    input  hdc_pkg::hv_t      m_dat_r,
    input  logic              m_ack,
    // Control levels for both lanes.
    output logic              run,
    output hdc_pkg::pos_t     ngram_len
);
    import hdc_pkg::*;

    logic wb_req;
    logic is_ctrl;
    logic ctrl_hit;
    logic im_start;
    hv_t  ctrl_rdata;

    // The ack term keeps a request that is still held from starting twice.
    assign wb_req   = wb_cyc & wb_stb & ~wb_ack;
    assign is_ctrl  = (wb_adr >= CTRL_ADDR);
    assign ctrl_hit = wb_req & is_ctrl & ~m_cyc;
    assign im_start = wb_req & ~is_ctrl & ~m_cyc;

    always_comb begin
        ctrl_rdata                 = '0;
        ctrl_rdata[CTRL_LEN_MSB:0] = ngram_len;
        ctrl_rdata[CTRL_RUN_BIT]   = run;
    end

    // ########################################
    // Control register and handshake.
    // ########################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            m_cyc     <= 1'b0;
            m_stb     <= 1'b0;
            run       <= 1'b0;
            ngram_len <= '0;        // A window of one symbol.
        end else begin
            wb_ack <= 1'b0;
            if (m_cyc) begin
                if (m_ack) begin
                    m_cyc  <= 1'b0;
                    m_stb  <= 1'b0;
                    wb_ack <= 1'b1;     // Host ack follows the arbiter ack.
                end
            end else if (ctrl_hit) begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    ngram_len <= wb_dat_w[CTRL_LEN_MSB:0];
                    run       <= wb_dat_w[CTRL_RUN_BIT];
                end
            end else if (im_start) begin
                m_cyc <= 1'b1;
                m_stb <= 1'b1;
            end
        end
    end

    // Item-memory request payload, held until the arbiter acks.
    always_ff @(posedge clk) begin
        if (im_start) begin
            m_we    <= wb_we;
            m_adr   <= wb_adr[WB_ADDR_WIDTH-1:WB_WORD_LSB];   // Word index.
            m_dat_w <= wb_dat_w;
        end
    end

    // Read data for the host.
    always_ff @(posedge clk) begin
        if (m_cyc && m_ack) begin
            wb_dat_r <= m_dat_r;
        end else if (ctrl_hit) begin
            wb_dat_r <= ctrl_rdata;
        end
    end

endmodule

//--- rtl/ngram_encoder.sv
`timescale 1ns/1ps

module ngram_encoder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  hdc_pkg::pos_t     ngram_len,     // Window length minus one.
    // Symbol intake.
    input  logic              sym_valid,
    input  hdc_pkg::im_addr_t sym_data,
    output logic              sym_ready,
    // Read-only master into the item memory arbiter.
    output logic              im_cyc,
    output logic              im_stb,
    output hdc_pkg::im_addr_t im_adr,
    input  hdc_pkg::hv_t      im_dat,
    input  logic              im_ack,
    // Bound n-gram output.
    output logic              res_valid,
    output hdc_pkg::hv_t      res_data,
    input  logic              res_ready
);
    import hdc_pkg::*;

    lane_state_t state;
    pos_t        pos;       // Position of the symbol being fetched.
    hv_t         acc;
    logic        last_pos;
    logic        fetch_done;
    hv_t         fetched_rot;

    // Rotate right by p. The doubled vector shifts the low bits round to the top.
    function automatic hv_t rot_right(input hv_t v, input pos_t p);
        logic [2*HV_WIDTH-1:0] dbl;
        dbl = {v, v} >> p;
        return dbl[HV_WIDTH-1:0];
    endfunction

    assign last_pos    = (pos == ngram_len);
    assign fetch_done  = (state == LANE_FETCH) && im_ack;
    assign fetched_rot = rot_right(im_dat, pos);

    // ########################################
    // Lane FSM.
    // ########################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= LANE_IDLE;
        end else begin
            unique case (state)
                LANE_IDLE: begin
                    if (sym_valid && sym_ready) begin
                        state <= LANE_FETCH;
                    end
                end
                LANE_FETCH: begin
                    // The request is held until ack even if run drops.
                    if (im_ack) begin
                        state <= (run && last_pos) ? LANE_EMIT : LANE_IDLE;
                    end
                end
                LANE_EMIT: begin
                    if (res_ready || !run) begin
                        state <= LANE_IDLE;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    // Position counter and accumulator.
    // Dropping run starts the next window afresh at position 0.
    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            pos <= '0;
            acc <= '0;
        end else if (fetch_done) begin
            if (pos == '0) begin
                acc <= im_dat;                  // First item is loaded as is.
            end else begin
                acc <= acc ^ fetched_rot;
            end
            pos <= last_pos ? pos_t'(0) : pos + 1'b1;
        end
    end

    // Symbol code doubles as the item-memory index.
    always_ff @(posedge clk) begin
        if (sym_valid && sym_ready) begin
            im_adr <= sym_data;
        end
    end

    assign sym_ready = run && (state == LANE_IDLE);
    assign im_cyc    = (state == LANE_FETCH);
    assign im_stb    = (state == LANE_FETCH);
    assign res_valid = (state == LANE_EMIT);
    assign res_data  = acc;                     // Stable while in emit.

endmodule

//--- rtl/hdc_encoder_top.sv
`timescale 1ns/1ps

module hdc_encoder_top (
    input  logic              clk,
    input  logic              rst_n,
    // Host Wishbone classic slave.
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  hdc_pkg::wb_addr_t wb_adr,
    input  hdc_pkg::hv_t      wb_dat_w,
    output hdc_pkg::hv_t      wb_dat_r,
    output logic              wb_ack,
    // Lane 0 symbols and results.
    input  logic              s0_valid,
    input  hdc_pkg::im_addr_t s0_data,
    output logic              s0_ready,
    output logic              r0_valid,
    output hdc_pkg::hv_t      r0_data,
    input  logic              r0_ready,
    // Lane 1 symbols and results.
    input  logic              s1_valid,
    input  hdc_pkg::im_addr_t s1_data,
    output logic              s1_ready,
    output logic              r1_valid,
    output hdc_pkg::hv_t      r1_data,
    input  logic              r1_ready
);
    import hdc_pkg::*;

    // ########################################
    // Interconnect.
    // ########################################
    logic     run;
    pos_t     ngram_len;

    logic     h_cyc, h_stb, h_we, h_ack;
    im_addr_t h_adr;
    hv_t      h_dat_w, h_dat_r;

    logic     l0_cyc, l0_stb, l0_ack;
    im_addr_t l0_adr;
    hv_t      l0_dat;

    logic     l1_cyc, l1_stb, l1_ack;
    im_addr_t l1_adr;
    hv_t      l1_dat;

    logic     mem_en, mem_we;
    im_addr_t mem_addr;
    hv_t      mem_wdata, mem_rdata;

    host_regs u_host_regs (
        .clk      (clk),       .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),    .wb_stb   (wb_stb),    .wb_we    (wb_we),
        .wb_adr   (wb_adr),    .wb_dat_w (wb_dat_w),  .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .m_cyc    (h_cyc),     .m_stb    (h_stb),     .m_we     (h_we),
        .m_adr    (h_adr),     .m_dat_w  (h_dat_w),   .m_dat_r  (h_dat_r),
        .m_ack    (h_ack),
        .run      (run),       .ngram_len(ngram_len)
    );

    im_arbiter u_arbiter (
        .clk      (clk),       .rst_n    (rst_n),
        .h_cyc    (h_cyc),     .h_stb    (h_stb),     .h_we     (h_we),
        .h_adr    (h_adr),     .h_dat_w  (h_dat_w),   .h_dat_r  (h_dat_r),
        .h_ack    (h_ack),
        .l0_cyc   (l0_cyc),    .l0_stb   (l0_stb),    .l0_adr   (l0_adr),
        .l0_dat   (l0_dat),    .l0_ack   (l0_ack),
        .l1_cyc   (l1_cyc),    .l1_stb   (l1_stb),    .l1_adr   (l1_adr),
        .l1_dat   (l1_dat),    .l1_ack   (l1_ack),
        .mem_en   (mem_en),    .mem_we   (mem_we),    .mem_addr (mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    item_memory u_item_memory (
        .clk      (clk),
        .mem_en   (mem_en),    .mem_we   (mem_we),    .mem_addr (mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    // Both lanes share run and the window length.
    ngram_encoder u_lane0 (
        .clk      (clk),       .rst_n    (rst_n),
        .run      (run),       .ngram_len(ngram_len),
        .sym_valid(s0_valid),  .sym_data (s0_data),   .sym_ready(s0_ready),
        .im_cyc   (l0_cyc),    .im_stb   (l0_stb),    .im_adr   (l0_adr),
        .im_dat   (l0_dat),    .im_ack   (l0_ack),
        .res_valid(r0_valid),  .res_data (r0_data),   .res_ready(r0_ready)
    );

    ngram_encoder u_lane1 (
        .clk      (clk),       .rst_n    (rst_n),
        .run      (run),       .ngram_len(ngram_len),
        .sym_valid(s1_valid),  .sym_data (s1_data),   .sym_ready(s1_ready),
        .im_cyc   (l1_cyc),    .im_stb   (l1_stb),    .im_adr   (l1_adr),
        .im_dat   (l1_dat),    .im_ack   (l1_ack),
        .res_valid(r1_valid),  .res_data (r1_data),   .res_ready(r1_ready)
    );

endmodule

//--- sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);

    // Free-running testbench clock with a 4 ns period.
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;    // Half period.
        end
    end

endmodule

//--- sim/hdc_model.svh
`ifndef HDC_MODEL_SVH
`define HDC_MODEL_SVH

// ########################################
// Reference model of the encoder.
// ########################################

// Mirror of the item memory, updated on every host write.
hv_t im_model [IM_DEPTH];

// Bit i of the result comes from bit i+p of the input,
// wrapping round at the top of the vector.
function automatic hv_t rotate_right(input hv_t v, input int p);
    hv_t r;
    for (int i = 0; i < HV_WIDTH; i++) begin
        r[i] = v[(i + p) % HV_WIDTH];
    end
    return r;
endfunction

// The first item of a window is taken as it is.
// Item k of the window is rotated right by k and XORed in.
function automatic hv_t encode_ngram(input im_addr_t syms [MAX_NGRAM], input int n);
    hv_t acc;
    acc = im_model[syms[0]];
    for (int k = 1; k < n; k++) begin
        acc = acc ^ rotate_right(im_model[syms[k]], k);
    end
    return acc;
endfunction

// Control word with the window length in bits 4:0 as length minus one.
function automatic hv_t ctrl_word(input int len, input logic run_v);
    hv_t w;
    w = hv_t'(len - 1) & hv_t'(MAX_NGRAM - 1);
    w[CTRL_RUN_BIT] = run_v;
    return w;
endfunction

`endif

//--- sim/tb_hdc_encoder.sv
`timescale 1ns/1ps

module tb_hdc_encoder;
    import hdc_pkg::*;

    `include "hdc_model.svh"

    // Only the words below the control register are reachable from the host.
    localparam int HOST_ITEMS  = int'(CTRL_ADDR) / 4;
    localparam int HOST_OPS    = HOST_ITEMS + 2 * 64 + 40 + 40;
    localparam int SYM_OPS     = 4 * (1 + 3 + 32) + 2 * 10 * 5 + 2 * 8 * 4 + 6;
    localparam int WATCHDOG_NS = (HOST_OPS + SYM_OPS) * 12 * 4 + 20000;

    logic                          clk;
    logic                          rst_n;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    wb_addr_t                      wb_adr;
    hv_t                           wb_dat_w;
    wire  [HV_WIDTH-1:0]           wb_dat_r;
    wire                           wb_ack;
    logic [1:0]                    s_valid;
    logic [1:0][IM_ADDR_WIDTH-1:0] s_data;
    wire  [1:0]                    s_ready;
    wire  [1:0]                    r_valid;
    wire  [1:0][HV_WIDTH-1:0]      r_data;
    logic [1:0]                    r_ready;

    int    errors;
    string test_name;
    logic  bp_on;          // Random back-pressure on both result ports.
    hv_t   exp0 [$];       // Expected results of lane 0 in window order.
    hv_t   exp1 [$];

    clk_gen u_clk_gen (.clk(clk));

    hdc_encoder_top DUT (
        .clk     (clk),        .rst_n   (rst_n),
        .wb_cyc  (wb_cyc),     .wb_stb  (wb_stb),     .wb_we   (wb_we),
        .wb_adr  (wb_adr),     .wb_dat_w(wb_dat_w),   .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack),
        .s0_valid(s_valid[0]), .s0_data (s_data[0]),  .s0_ready(s_ready[0]),
        .r0_valid(r_valid[0]), .r0_data (r_data[0]),  .r0_ready(r_ready[0]),
        .s1_valid(s_valid[1]), .s1_data (s_data[1]),  .s1_ready(s_ready[1]),
        .r1_valid(r_valid[1]), .r1_data (r_data[1]),  .r1_ready(r_ready[1])
    );

    // ########################################
    // Drivers. All start and end on a falling edge.
    // ########################################
    task automatic host_access(input logic we, input wb_addr_t adr, input hv_t wdata,
                               output hv_t rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        rdata  = wb_dat_r;    // Registered together with the ack.
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic set_ctrl(input int len, input logic run_v);
        hv_t ignored;
        host_access(1'b1, CTRL_ADDR, ctrl_word(len, run_v), ignored);
    endtask

    task automatic send_symbol(input int lane, input im_addr_t sym);
        s_valid[lane] = 1'b1;
        s_data[lane]  = sym;
        while (!s_ready[lane]) @(negedge clk);
        @(negedge clk);       // The transfer happened on the rising edge in between.
        s_valid[lane] = 1'b0;
    endtask

    task automatic send_window(input int lane, input int n);
        im_addr_t syms [MAX_NGRAM];
        hv_t      expected;
        for (int k = 0; k < n; k++) begin
            syms[k] = im_addr_t'($urandom_range(0, HOST_ITEMS - 1));
        end
        expected = encode_ngram(syms, n);
        if (lane == 0) exp0.push_back(expected);
        else exp1.push_back(expected);
        for (int k = 0; k < n; k++) begin
            send_symbol(lane, syms[k]);
        end
    endtask

    task automatic wait_drained();
        while (exp0.size() != 0 || exp1.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    // Drives res_ready of one lane and checks every result that it accepts.
    task automatic watch_results(input int lane);
        int   stall;
        logic held;
        hv_t  held_data;
        hv_t  expected;
        stall = 0;
        held  = 1'b0;
        forever begin
            @(negedge clk);
            if (held && !r_valid[lane]) begin
                $display("Lane %0d withdrew a result before it was accepted", lane);
                errors++;
            end
            if (held && r_valid[lane] && r_data[lane] !== held_data) begin
                $display("ERROR %s lane %0d hold: expected %h, got %h",
                         test_name, lane, held_data, r_data[lane]);
                errors++;
            end
            if (r_valid[lane] && s_ready[lane]) begin
                $display("Lane %0d is ready for symbols while a result waits", lane);
                errors++;
            end
            if (!bp_on) begin
                r_ready[lane] = 1'b1;
            end else if (stall > 0) begin
                r_ready[lane] = 1'b0;
                stall--;
            end else if ($urandom_range(0, 3) == 0) begin
                r_ready[lane] = 1'b0;
                stall         = $urandom_range(1, 10);
            end else begin
                r_ready[lane] = 1'b1;
            end
            held      = r_valid[lane] && !r_ready[lane];
            held_data = r_data[lane];
            if (r_valid[lane] && r_ready[lane]) begin
                if ((lane == 0 && exp0.size() == 0) || (lane == 1 && exp1.size() == 0)) begin
                    $display("Lane %0d produced a result that no window asked for", lane);
                    errors++;
                end else begin
                    if (lane == 0) expected = exp0.pop_front();
                    else expected = exp1.pop_front();
                    if (r_data[lane] !== expected) begin
                        $display("ERROR %s lane %0d: expected %h, got %h",
                                 test_name, lane, expected, r_data[lane]);
                        errors++;
                    end
                end
            end
        end
    endtask

    // ########################################
    // Test sequence.
    // ########################################
    initial begin
        hv_t  rd;
        hv_t  wr;
        hv_t  expected;
        int   idx;
        int   n;
        logic run_v;
        int   idx_list [64];
        int   lengths [3];
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        s_valid   = '0;
        s_data    = '0;
        r_ready   = '0;
        rst_n     = 1'b0;
        bp_on     = 1'b0;
        errors    = 0;
        test_name = "reset";
        void'($urandom(32'he416));
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        fork
            watch_results(0);
            watch_results(1);
        join_none
        @(negedge clk);

        test_name = "ctrl_reset";
        host_access(1'b0, CTRL_ADDR, '0, rd);
        if (rd !== '0) begin
            $display("ERROR %s: expected %h, got %h", test_name, 32'h0, rd);
            errors++;
        end
        if (s_ready !== 2'b00) begin
            $display("A lane is ready for symbols although run is low after reset");
            errors++;
        end
        test_name = "ctrl_rw";
        repeat (8) begin
            n        = $urandom_range(1, MAX_NGRAM);
            run_v    = $urandom_range(0, 1);
            expected = ctrl_word(n, run_v);
            set_ctrl(n, run_v);
            host_access(1'b0, CTRL_ADDR, '0, rd);
            if (rd !== expected) begin
                $display("ERROR %s: expected %h, got %h", test_name, expected, rd);
                errors++;
            end
        end
        set_ctrl(1, 1'b0);

        test_name = "im_load";
        for (int i = 0; i < HOST_ITEMS; i++) begin
            wr          = $urandom;
            im_model[i] = wr;
            host_access(1'b1, wb_addr_t'(i * 4), wr, rd);
        end
        test_name = "im_round_trip";
        foreach (idx_list[i]) begin
            idx           = $urandom_range(0, HOST_ITEMS - 1);
            idx_list[i]   = idx;
            wr            = $urandom;
            im_model[idx] = wr;
            host_access(1'b1, wb_addr_t'(idx * 4), wr, rd);
        end
        foreach (idx_list[i]) begin
            host_access(1'b0, wb_addr_t'(idx_list[i] * 4), '0, rd);
            if (rd !== im_model[idx_list[i]]) begin
                $display("ERROR %s: expected %h, got %h", test_name, im_model[idx_list[i]], rd);
                errors++;
            end
        end

        test_name = "single_lane";
        lengths   = '{1, 3, 32};
        foreach (lengths[i]) begin
            set_ctrl(lengths[i], 1'b1);
            repeat (4) send_window(0, lengths[i]);
            wait_drained();
        end

        test_name = "contention";
        set_ctrl(5, 1'b1);
        fork
            repeat (10) send_window(0, 5);
            repeat (10) send_window(1, 5);
            repeat (40) begin
                idx = $urandom_range(0, HOST_ITEMS - 1);
                host_access(1'b0, wb_addr_t'(idx * 4), '0, rd);
                if (rd !== im_model[idx]) begin
                    $display("ERROR %s: expected %h, got %h", test_name, im_model[idx], rd);
                    errors++;
                end
            end
        join
        wait_drained();

        test_name = "back_pressure";
        set_ctrl(4, 1'b1);
        bp_on = 1'b1;
        fork
            repeat (8) send_window(0, 4);
            repeat (8) send_window(1, 4);
        join
        wait_drained();
        bp_on = 1'b0;

        // Two symbols of a window are taken, then run drops and the window restarts.
        test_name = "run_clear";
        send_symbol(0, im_addr_t'($urandom_range(0, HOST_ITEMS - 1)));
        send_symbol(0, im_addr_t'($urandom_range(0, HOST_ITEMS - 1)));
        while (!s_ready[0]) @(negedge clk);
        set_ctrl(4, 1'b0);
        set_ctrl(4, 1'b1);
        send_window(0, 4);
        wait_drained();

        repeat (4) @(negedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Ends a run that no longer makes progress.
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns during %s", WATCHDOG_NS, test_name);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+sim
rtl/hdc_pkg.sv
rtl/item_memory.sv
rtl/im_arbiter.sv
rtl/host_regs.sv
rtl/ngram_encoder.sv
rtl/hdc_encoder_top.sv
sim/clk_gen.sv
sim/tb_hdc_encoder.sv

//--- Bender.yml
package:
  name: hdc_encoder

sources:
  - files:
      - rtl/hdc_pkg.sv
      - rtl/item_memory.sv
      - rtl/im_arbiter.sv
      - rtl/host_regs.sv
      - rtl/ngram_encoder.sv
      - rtl/hdc_encoder_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/clk_gen.sv
      - sim/tb_hdc_encoder.sv
